// ==== rtl/bpu_cfg_pkg.sv ====
// geometry, reset pc and index helpers of the branch predictor
// imported by the tables, the pc generator and the update controller
package bpu_cfg_pkg;

    localparam int unsigned BTB_IDX_W = 6;               // btb and bht index
    localparam int unsigned BTB_DEPTH = 1 << BTB_IDX_W;
    localparam int unsigned TAG_W     = 8;               // pc[22:15]
    localparam int unsigned HIST_W    = 2;               // local history length
    localparam int unsigned PHT_PC_W  = 6;               // pc[8:3]
    localparam int unsigned PHT_IDX_W = HIST_W + PHT_PC_W;
    localparam int unsigned PHT_DEPTH = 1 << PHT_IDX_W;  // also the sweep length
    localparam int unsigned RAS_DEPTH = 8;
    localparam int unsigned RAS_PTR_W = 3;
    localparam logic [31:0] INIT_PC   = 32'h1c00_0000;

    // btb and bht set index, folded from two pc slices
    function automatic logic [BTB_IDX_W-1:0] btb_hash(input logic [31:0] pc);
        return pc[8:3] ^ pc[14:9];
    endfunction

    function automatic logic [TAG_W-1:0] btb_tag(input logic [31:0] pc);
        return pc[22:15];
    endfunction

endpackage

// ==== rtl/bpu_types_pkg.sv ====
// branch types, btb entry layout and counter update rule
// shared by the tables, the pc generator and the update controller
package bpu_types_pkg;
    import bpu_cfg_pkg::*;

    typedef enum logic [1:0] {
        NORMAL = 2'd0,  // conditional
        JUMP   = 2'd1,
        CALL   = 2'd2,
        RET    = 2'd3
    } br_type_e;

    // one btb word
    typedef struct packed {
        logic             valid;
        logic [TAG_W-1:0] tag;
        logic [31:0]      target;
        br_type_e         br_type;
    } btb_entry_t;

    localparam logic [1:0] SCNT_INIT = 2'b01;  // weakly not taken

    // 2-bit saturating counter step
    function automatic logic [1:0] next_scnt(input logic [1:0] scnt, input logic taken);
        logic [1:0] res;
        if (taken) begin
            res = (scnt == 2'b11) ? 2'b11 : scnt + 2'b01;
        end else begin
            res = (scnt == 2'b00) ? 2'b00 : scnt - 2'b01;
        end
        return res;
    endfunction

endpackage

// ==== rtl/bpu_update_if.sv ====
// table write port, from the update controller to btb and direction tables
// carries either one backend correction or one step of the reset sweep
`timescale 1ns/10ps

interface bpu_update_if
    import bpu_cfg_pkg::*;
    import bpu_types_pkg::*;
();

    logic [1:0]           we_bank;     // one enable per slot bank
    logic [BTB_IDX_W-1:0] widx;        // btb and bht row
    btb_entry_t           wentry;
    logic [HIST_W-1:0]    hist_wdata;
    logic [PHT_IDX_W-1:0] pht_widx;
    logic [1:0]           pht_wdata;

    modport ctrl (
        output we_bank,
        output widx,
        output wentry,
        output hist_wdata,
        output pht_widx,
        output pht_wdata
    );

    modport tbl (
        input we_bank,
        input widx,
        input wentry,
        input hist_wdata,
        input pht_widx,
        input pht_wdata
    );

endinterface

// ==== rtl/bpu_lookup_if.sv ====
// lookup path between the pc generator and the predictor tables
// rd_pc addresses the synchronous reads, results line up with cur_pc
`timescale 1ns/10ps

interface bpu_lookup_if
    import bpu_cfg_pkg::*;
    import bpu_types_pkg::*;
();

    logic [31:0]                  rd_pc;   // next pc
    logic [31:0]                  cur_pc;  // registered pc
    btb_entry_t [1:0]             entry;
    logic [1:0]                   hit;
    logic [1:0][HIST_W-1:0]       hist;
    logic [1:0][1:0]              scnt;

    modport pcgen (
        output rd_pc, cur_pc,
        input  entry, hit, hist, scnt
    );

    modport tbl (
        input  rd_pc, cur_pc,
        output entry, hit, hist, scnt
    );

endinterface

// ==== rtl/bpu_update_ctrl.sv ====
// picks one backend correction per cycle and forms all table write data
// after reset it sweeps every table row before predictions begin
`timescale 1ns/10ps

module bpu_update_ctrl
    import bpu_cfg_pkg::*;
    import bpu_types_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic [1:0]             upd_valid_i,
    input  logic [1:0][31:0]       upd_pc_i,
    input  logic [1:0][31:0]       upd_target_i,
    input  br_type_e [1:0]         upd_type_i,
    input  logic [1:0]             upd_is_branch_i,
    input  logic [1:0]             upd_taken_i,
    input  logic [1:0]             upd_type_miss_i,
    input  logic [1:0][HIST_W-1:0] upd_hist_i,
    input  logic [1:0][1:0]        upd_scnt_i,
    output logic                   sweeping_o,
    bpu_update_if.ctrl             upd
);

    logic [PHT_IDX_W-1:0] sweep_cnt;
    logic                 sweeping;
    logic                 sel;     // chosen candidate
    logic                 apply;
    logic [31:0]          pc;

    always_ff @(posedge clk) begin
        if (rst) begin
            sweep_cnt <= '0;
            sweeping  <= 1'b1;
        end else if (sweeping) begin
            sweep_cnt <= sweep_cnt + 1'b1;
            if (&sweep_cnt) begin
                sweeping <= 1'b0;  // last row written this cycle
            end
        end
    end

    assign sweeping_o = sweeping;
    assign sel   = ~upd_valid_i[0];
    assign apply = |upd_valid_i;
    assign pc    = upd_pc_i[sel];

    always_comb begin
        if (sweeping) begin
            upd.we_bank    = 2'b11;
            upd.widx       = sweep_cnt[BTB_IDX_W-1:0];
            upd.wentry     = '0;
            upd.hist_wdata = '0;
            upd.pht_widx   = sweep_cnt;
            upd.pht_wdata  = SCNT_INIT;
        end else begin
            upd.we_bank        = {apply & pc[2], apply & ~pc[2]};  // pc bit 2 picks the bank
            upd.widx           = btb_hash(pc);
            upd.wentry.valid   = upd_is_branch_i[sel];
            upd.wentry.tag     = btb_tag(pc);
            upd.wentry.target  = upd_target_i[sel];
            upd.wentry.br_type = upd_type_i[sel];
            // a wrong type restarts the history
            upd.hist_wdata = upd_type_miss_i[sel] ? {HIST_W{upd_taken_i[sel]}} :
                             {upd_hist_i[sel][HIST_W-2:0], upd_taken_i[sel]};
            upd.pht_widx   = {upd_hist_i[sel], pc[PHT_PC_W+2:3]};
            upd.pht_wdata  = next_scnt(upd_scnt_i[sel], upd_taken_i[sel]);
        end
    end

endmodule

// ==== rtl/bpu_btb.sv ====
// two-bank tagged branch target buffer, one bank per slot
// read is registered from rd_pc, hit compares against cur_pc
`timescale 1ns/10ps

module bpu_btb
    import bpu_cfg_pkg::*;
    import bpu_types_pkg::*;
(
    input logic       clk,
    bpu_update_if.tbl upd,
    bpu_lookup_if.tbl lkp
);

    logic [BTB_IDX_W-1:0] ridx;
    logic [TAG_W-1:0]     cur_tag;

    assign ridx    = btb_hash(lkp.rd_pc);
    assign cur_tag = btb_tag(lkp.cur_pc);

    for (genvar b = 0; b < 2; b++) begin : g_bank
        btb_entry_t mem [BTB_DEPTH];
        btb_entry_t rd_q;

        // write port, rows cleared by the sweep
        always_ff @(posedge clk) begin
            if (upd.we_bank[b]) begin
                mem[upd.widx] <= upd.wentry;
            end
        end

        // old data on a same-row write
        always_ff @(posedge clk) begin
            rd_q <= mem[ridx];
        end

        assign lkp.entry[b] = rd_q;
        assign lkp.hit[b]   = rd_q.valid && (rd_q.tag == cur_tag);
    end

endmodule

// ==== rtl/bpu_dir_pred.sv ====
// direction predictor: per-bank local history feeding 2-bit counters
// history row is registered from rd_pc, counter row comes from cur_pc
`timescale 1ns/10ps

module bpu_dir_pred
    import bpu_cfg_pkg::*;
(
    input logic       clk,
    bpu_update_if.tbl upd,
    bpu_lookup_if.tbl lkp
);

    logic [BTB_IDX_W-1:0] hidx_q;  // same row as the btb read
    logic [PHT_PC_W-1:0]  pc_bits;

    always_ff @(posedge clk) begin
        hidx_q <= btb_hash(lkp.rd_pc);
    end

    assign pc_bits = lkp.cur_pc[PHT_PC_W+2:3];

    for (genvar b = 0; b < 2; b++) begin : g_bank
        logic [HIST_W-1:0]    bht [BTB_DEPTH];
        logic [1:0]           pht [PHT_DEPTH];
        logic [PHT_IDX_W-1:0] pidx;

        always_ff @(posedge clk) begin
            if (upd.we_bank[b]) begin
                bht[upd.widx] <= upd.hist_wdata;
            end
        end

        // counters share the bank enable
        always_ff @(posedge clk) begin
            if (upd.we_bank[b]) begin
                pht[upd.pht_widx] <= upd.pht_wdata;
            end
        end

        assign lkp.hist[b] = bht[hidx_q];
        assign pidx        = {lkp.hist[b], pc_bits};  // history then pc
        assign lkp.scnt[b] = pht[pidx];
    end

endmodule

// ==== rtl/bpu_ras.sv ====
// return address stack, grows upward and wraps on overflow
// push on predicted calls, pop on predicted returns
`timescale 1ns/10ps

module bpu_ras
    import bpu_cfg_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        push_i,
    input  logic        pop_i,
    input  logic [31:0] push_addr_i,
    output logic [31:0] top_o
);

    logic [31:0]          stack [RAS_DEPTH];
    logic [RAS_PTR_W-1:0] top_ptr;  // last pushed entry
    logic [RAS_PTR_W-1:0] w_ptr;    // next free entry

    always_ff @(posedge clk) begin
        if (push_i) begin
            stack[w_ptr] <= push_addr_i;
        end
    end

    // push wins over pop
    always_ff @(posedge clk) begin
        if (rst) begin
            top_ptr <= '1;
            w_ptr   <= '0;
        end else if (push_i) begin
            top_ptr <= w_ptr;
            w_ptr   <= w_ptr + 1'b1;
        end else if (pop_i) begin
            w_ptr   <= top_ptr;
            top_ptr <= top_ptr - 1'b1;
        end
    end

    assign top_o = stack[top_ptr];

endmodule

// ==== rtl/bpu_pc_gen.sv ====
// fetch pc register and next pc selection
// forms the slot mask and per-slot predictions, drives ras push and pop
`timescale 1ns/10ps

module bpu_pc_gen
    import bpu_cfg_pkg::*;
    import bpu_types_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   flush_i,
    input  logic [31:0]            redir_addr_i,
    input  logic                   ready_i,
    input  logic                   sweeping_i,
    bpu_lookup_if.pcgen            lkp,
    input  logic [31:0]            ras_top_i,
    output logic                   ras_push_o,
    output logic                   ras_pop_o,
    output logic [31:0]            ras_push_addr_o,
    output logic                   valid_o,
    output logic [31:0]            pc_o,
    output logic [1:0]             mask_o,
    output logic [1:0]             taken_o,
    output logic [1:0][31:0]       target_o,
    output logic [1:0][HIST_W-1:0] hist_o,
    output logic [1:0][1:0]        scnt_o,
    output logic [1:0]             miss_o
);

    logic [31:0]      pc_q;
    logic [31:0]      pc_next;
    logic             valid_q;
    logic             accept;
    logic             flush;
    logic [1:0]       taken;     // raw per-slot prediction
    logic [1:0]       mask;
    logic [1:0]       fire;      // taken and in mask
    logic [1:0][31:0] target;
    logic [1:0][31:0] ret_addr;  // slot pc plus 4
    logic [31:0]      pc_add8;

    assign accept  = valid_q & ready_i;
    assign flush   = flush_i & valid_q;
    assign pc_add8 = {pc_q[31:3] + 29'd1, 3'b000};

    for (genvar i = 0; i < 2; i++) begin : g_slot
        assign taken[i]  = lkp.hit[i] &&
                           (lkp.entry[i].br_type != NORMAL || lkp.scnt[i][1]);
        assign target[i] = (lkp.entry[i].br_type == RET) ? ras_top_i : lkp.entry[i].target;
    end

    assign mask        = {~(mask[0] & taken[0]), ~pc_q[2]};
    assign fire        = taken & mask;
    assign ret_addr[0] = {pc_q[31:3], 3'b100};
    assign ret_addr[1] = pc_add8;

    always_comb begin
        if (rst) begin
            pc_next = INIT_PC;
        end else if (flush) begin
            pc_next = {redir_addr_i[31:2], 2'b00};
        end else if (!accept) begin
            pc_next = pc_q;  // hold
        end else if (fire[0]) begin
            pc_next = target[0];
        end else if (taken[1]) begin
            pc_next = target[1];
        end else begin
            pc_next = pc_add8;
        end
    end

    // first taken slot of an accepted group drives the ras
    always_comb begin
        ras_push_o      = 1'b0;
        ras_pop_o       = 1'b0;
        ras_push_addr_o = ret_addr[0];
        if (accept && !flush) begin
            if (fire[0]) begin
                ras_push_o = (lkp.entry[0].br_type == CALL);
                ras_pop_o  = (lkp.entry[0].br_type == RET);
            end else if (fire[1]) begin
                ras_push_o      = (lkp.entry[1].br_type == CALL);
                ras_pop_o       = (lkp.entry[1].br_type == RET);
                ras_push_addr_o = ret_addr[1];
            end
        end
    end

    always_ff @(posedge clk) begin
        pc_q <= pc_next;
    end

    // low through the sweep and one cycle after it
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= ~sweeping_i;
        end
    end

    assign lkp.rd_pc  = pc_next;
    assign lkp.cur_pc = pc_q;

    assign valid_o  = valid_q;
    assign pc_o     = pc_q;
    assign mask_o   = mask;
    assign taken_o  = fire;
    assign target_o = target;
    assign hist_o   = lkp.hist;
    assign scnt_o   = lkp.scnt;
    assign miss_o   = ~lkp.hit;  // backend must train these slots

endmodule

// ==== rtl/bpu_top.sv ====
// two-wide branch prediction unit top level
// one fetch group per accepted cycle, backend corrections on the upd_* ports
`timescale 1ns/10ps

module bpu_top
    import bpu_cfg_pkg::*;
    import bpu_types_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   flush_i,
    input  logic [31:0]            redir_addr_i,
    input  logic                   ready_i,
    input  logic [1:0]             upd_valid_i,
    input  logic [1:0][31:0]       upd_pc_i,
    input  logic [1:0][31:0]       upd_target_i,
    input  br_type_e [1:0]         upd_type_i,
    input  logic [1:0]             upd_is_branch_i,
    input  logic [1:0]             upd_taken_i,
    input  logic [1:0]             upd_type_miss_i,
    input  logic [1:0][HIST_W-1:0] upd_hist_i,
    input  logic [1:0][1:0]        upd_scnt_i,
    output logic                   valid_o,
    output logic [31:0]            pc_o,
    output logic [1:0]             mask_o,
    output logic [1:0]             taken_o,
    output logic [1:0][31:0]       target_o,
    output logic [1:0][HIST_W-1:0] hist_o,
    output logic [1:0][1:0]        scnt_o,
    output logic [1:0]             miss_o
);

    logic        sweeping;
    logic        ras_push;
    logic        ras_pop;
    logic [31:0] ras_push_addr;
    logic [31:0] ras_top;

    bpu_update_if upd_if ();
    bpu_lookup_if lkp_if ();

    bpu_update_ctrl update_ctrl_i (
        .clk, .rst,
        .upd_valid_i, .upd_pc_i, .upd_target_i, .upd_type_i, .upd_is_branch_i,
        .upd_taken_i, .upd_type_miss_i, .upd_hist_i, .upd_scnt_i,
        .sweeping_o (sweeping),
        .upd        (upd_if.ctrl)
    );

    bpu_btb btb_i (.clk, .upd(upd_if.tbl), .lkp(lkp_if.tbl));

    bpu_dir_pred dir_pred_i (.clk, .upd(upd_if.tbl), .lkp(lkp_if.tbl));

    bpu_ras ras_i (
        .clk, .rst,
        .push_i      (ras_push),
        .pop_i       (ras_pop),
        .push_addr_i (ras_push_addr),
        .top_o       (ras_top)
    );

    bpu_pc_gen pc_gen_i (
        .clk, .rst, .flush_i, .redir_addr_i, .ready_i,
        .sweeping_i      (sweeping),
        .lkp             (lkp_if.pcgen),
        .ras_top_i       (ras_top),
        .ras_push_o      (ras_push),
        .ras_pop_o       (ras_pop),
        .ras_push_addr_o (ras_push_addr),
        .valid_o, .pc_o, .mask_o, .taken_o, .target_o, .hist_o, .scnt_o, .miss_o
    );

endmodule

// ==== tb/bpu_sva.sv ====
// concurrent checks on the predictor top level, attached to bpu_top by bind
// reset behaviour, output hold under back-pressure and pc alignment
`timescale 1ns/10ps

module bpu_sva
    import bpu_cfg_pkg::*;
(
    input logic                   clk,
    input logic                   rst,
    input logic                   flush_i,
    input logic                   ready_i,
    input logic [1:0]             upd_valid_i,
    input logic                   valid_o,
    input logic [31:0]            pc_o,
    input logic [1:0]             mask_o,
    input logic [1:0]             taken_o,
    input logic [1:0][31:0]       target_o,
    input logic [1:0][HIST_W-1:0] hist_o,
    input logic [1:0][1:0]        scnt_o,
    input logic [1:0]             miss_o
);

    logic quiet_hold;  // stalled group, no redirect, no table write this cycle

    assign quiet_hold = valid_o && !ready_i && !flush_i && (upd_valid_i == 2'b00);

    valid_low_in_reset: assert property (@(posedge clk) rst |=> !valid_o)
        else $error("valid_o high in the cycle after reset");

    // a write two cycles back would still reach the btb read
    outputs_hold: assert property (@(posedge clk) disable iff (rst)
        quiet_hold && ($past(upd_valid_i) == 2'b00) |=>
            $stable(valid_o) && $stable(pc_o) && $stable(mask_o) && $stable(taken_o) &&
            $stable(target_o) && $stable(hist_o) && $stable(scnt_o) && $stable(miss_o))
        else $error("outputs changed while the group was stalled");

    pc_aligned: assert property (@(posedge clk) disable iff (rst) pc_o[1:0] == 2'b00)
        else $error("pc_o not word aligned");

endmodule

// ==== tb/bpu_tb.sv ====
// directed testbench for the two-wide branch prediction unit
// trains the tables through the correction ports and checks the predictions
`timescale 1ns/10ps

module bpu_tb
    import bpu_cfg_pkg::*;
    import bpu_types_pkg::*;
();

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 4;
    localparam int SWEEP_CYCLES = 256;
    // rough per-test lengths, in test order
    localparam int TEST_CYCLES  = 12 + 4 + 8 + 24 + 14 + 8;
    localparam int WATCHDOG_CYCLES = 2 * (RESET_CYCLES + SWEEP_CYCLES + 1 + TEST_CYCLES);

    logic                   clk;
    logic                   rst;
    logic                   flush;
    logic [31:0]            redir_addr;
    logic                   ready;
    logic [1:0]             upd_valid;
    logic [1:0][31:0]       upd_pc;
    logic [1:0][31:0]       upd_target;
    br_type_e [1:0]         upd_type;
    logic [1:0]             upd_is_branch;
    logic [1:0]             upd_taken;
    logic [1:0]             upd_type_miss;
    logic [1:0][HIST_W-1:0] upd_hist;
    logic [1:0][1:0]        upd_scnt;
    logic                   valid;
    logic [31:0]            pc;
    logic [1:0]             mask;
    logic [1:0]             taken;
    logic [1:0][31:0]       target;
    logic [1:0][HIST_W-1:0] hist;
    logic [1:0][1:0]        scnt;
    logic [1:0]             miss;
    integer                 seed;

    bpu_top dut_i (
        .clk, .rst,
        .flush_i         (flush),
        .redir_addr_i    (redir_addr),
        .ready_i         (ready),
        .upd_valid_i     (upd_valid),
        .upd_pc_i        (upd_pc),
        .upd_target_i    (upd_target),
        .upd_type_i      (upd_type),
        .upd_is_branch_i (upd_is_branch),
        .upd_taken_i     (upd_taken),
        .upd_type_miss_i (upd_type_miss),
        .upd_hist_i      (upd_hist),
        .upd_scnt_i      (upd_scnt),
        .valid_o         (valid),
        .pc_o            (pc),
        .mask_o          (mask),
        .taken_o         (taken),
        .target_o        (target),
        .hist_o          (hist),
        .scnt_o          (scnt),
        .miss_o          (miss)
    );

    bind bpu_top bpu_sva sva_i (
        .clk, .rst, .flush_i, .ready_i, .upd_valid_i, .valid_o, .pc_o,
        .mask_o, .taken_o, .target_o, .hist_o, .scnt_o, .miss_o
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic stop_failed();
        $display("TEST FAIL");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic check(input logic [31:0] exp, input logic [31:0] act, input string what);
        if (act !== exp) begin
            $display("CHECK FAILED at %0t ns: %s, expected %h, got %h", $time, what, exp, act);
            stop_failed();
        end
    endtask

    // one clock, then inputs may change
    task automatic step();
        @(posedge clk);
        #1;
    endtask

    // 2-bit saturating counter, written from the counter rule
    function automatic logic [1:0] sat_step(input logic [1:0] cnt, input logic up);
        int v;
        v = up ? int'(cnt) + 1 : int'(cnt) - 1;
        if (v > 3) begin
            v = 3;
        end
        if (v < 0) begin
            v = 0;
        end
        return v[1:0];
    endfunction

    // random word pc with a chosen btb tag and slot
    function automatic logic [31:0] rand_pc(input logic [7:0] tag, input logic slot);
        logic [31:0] r;
        r = $random(seed);
        return {r[31:23], tag, r[14:3], slot, 2'b00};
    endfunction

    task automatic wait_valid(input int max_cycles, output int cycles);
        cycles = 0;
        while (!valid) begin
            if (cycles >= max_cycles) begin
                $display("timeout: valid_o did not rise within %0d cycles of reset release",
                         max_cycles);
                stop_failed();
            end
            step();
            cycles++;
        end
    endtask

    task automatic set_candidate(input int k, input logic [31:0] bpc, input logic [31:0] tgt,
                                 input br_type_e btype, input logic tk, input logic tmiss,
                                 input logic [1:0] h, input logic [1:0] cnt);
        upd_pc[k]        = bpc;
        upd_target[k]    = tgt;
        upd_type[k]      = btype;
        upd_is_branch[k] = 1'b1;
        upd_taken[k]     = tk;
        upd_type_miss[k] = tmiss;
        upd_hist[k]      = h;
        upd_scnt[k]      = cnt;
    endtask

    // single correction on candidate 0, one cycle
    task automatic apply_correction(input logic [31:0] bpc, input logic [31:0] tgt,
                                    input br_type_e btype, input logic tk, input logic tmiss,
                                    input logic [1:0] h, input logic [1:0] cnt);
        set_candidate(0, bpc, tgt, btype, tk, tmiss, h, cnt);
        upd_valid = 2'b01;
        step();
        upd_valid = 2'b00;
    endtask

    task automatic flush_to(input logic [31:0] addr);
        flush      = 1'b1;
        redir_addr = addr;
        step();
        flush      = 1'b0;
    endtask

    task automatic accept_one();
        ready = 1'b1;
        step();
        ready = 1'b0;
    endtask

    task automatic reset_and_sequential();
        logic [31:0] exp_pc;
        int          n;
        rst = 1'b1;
        repeat (RESET_CYCLES) begin
            step();
            check(1'b0, valid, "valid_o during reset");
        end
        rst = 1'b0;
        wait_valid(SWEEP_CYCLES + 8, n);
        check(SWEEP_CYCLES + 1, n, "cycles from reset release to valid_o");
        check(INIT_PC, pc, "pc after sweep");
        check(2'b11, mask, "mask of first group");
        check(2'b00, taken, "taken of first group");
        exp_pc = INIT_PC;
        ready  = 1'b1;
        repeat (3) begin
            step();
            exp_pc = exp_pc + 32'd8;
            check(exp_pc, pc, "sequential pc");
        end
        ready = 1'b0;
        repeat (3) begin
            step();
            check(exp_pc, pc, "pc held while not ready");
        end
    endtask

    task automatic flush_redirect();
        logic [31:0] addr;
        addr = rand_pc(8'h21, 1'b1);
        flush_to(addr);
        check(addr, pc, "pc after flush");
        check(2'b10, mask, "mask at odd-slot pc");
        check(2'b11, miss, "miss on untrained group");
        check(2'b00, taken, "taken on untrained group");
    endtask

    task automatic jump_training();
        logic [31:0] a;
        logic [31:0] t;
        a = rand_pc(8'h31, 1'b0);
        t = rand_pc(8'h71, 1'b0);
        apply_correction(a, t, JUMP, 1'b1, 1'b1, 2'b00, 2'b01);
        flush_to(a);
        check(1'b0, miss[0], "slot 0 miss after jump training");
        check(2'b01, taken, "jump taken in slot 0");
        check(t, target[0], "jump target");
        check(2'b01, mask, "slot 1 masked behind taken jump");
        // type miss with taken fills the history with ones
        check(2'b11, hist[0], "slot 0 history after type miss");
        check(2'b01, scnt[0], "slot 0 counter at the new history");
        accept_one();
        check(t, pc, "pc after taken jump");
    endtask

    task automatic counter_training();
        logic [31:0] b;
        logic [31:0] t;
        logic [1:0]  m_pht [4];  // counters of this pc, by history
        logic [1:0]  m_hist;
        logic        exp_tk;
        int          i;
        b = rand_pc(8'h41, 1'b1);
        t = rand_pc(8'h72, 1'b0);
        for (i = 0; i < 4; i++) begin
            m_pht[i] = 2'b01;  // weakly not taken after sweep
        end
        m_hist = 2'b00;
        for (i = 0; i < 6; i++) begin
            flush_to(b);
            exp_tk = (i > 0) && m_pht[m_hist][1];
            check(2'b10, mask, "mask for slot 1 branch");
            check(i == 0, miss[1], "slot 1 miss");
            check(m_hist, hist[1], "slot 1 history");
            check(m_pht[m_hist], scnt[1], "slot 1 counter");
            check({exp_tk, 1'b0}, taken, "conditional prediction");
            if (exp_tk) begin
                check(t, target[1], "conditional target");
            end
            apply_correction(b, t, NORMAL, 1'b1, 1'b0, m_hist, m_pht[m_hist]);
            m_pht[m_hist] = sat_step(m_pht[m_hist], 1'b1);
            m_hist = {m_hist[0], 1'b1};  // shift in taken
        end
    endtask

    task automatic call_return();
        logic [31:0] a;
        logic [31:0] c;
        logic [31:0] r;
        a = rand_pc(8'h51, 1'b0);
        c = rand_pc(8'h73, 1'b0);
        r = rand_pc(8'h52, 1'b1);
        apply_correction(a, c, CALL, 1'b1, 1'b1, 2'b00, 2'b01);
        apply_correction(r, 32'h0, RET, 1'b1, 1'b1, 2'b00, 2'b01);
        flush_to(a);
        check(2'b01, taken, "call taken in slot 0");
        check(c, target[0], "call target");
        accept_one();  // pushes a + 4
        check(c, pc, "pc after call");
        flush_to(r);
        check(2'b10, mask, "mask at return group");
        check(2'b10, taken, "return taken in slot 1");
        check(a + 32'd4, target[1], "return target from stack");
        accept_one();
        check(a + 32'd4, pc, "pc after return");
    endtask

    task automatic two_corrections();
        logic [31:0] p0;
        logic [31:0] p1;
        logic [31:0] t0;
        p0 = rand_pc(8'h61, 1'b0);
        p1 = rand_pc(8'h62, 1'b1);
        t0 = rand_pc(8'h74, 1'b0);
        set_candidate(0, p0, t0, JUMP, 1'b1, 1'b1, 2'b00, 2'b01);
        set_candidate(1, p1, rand_pc(8'h75, 1'b0), JUMP, 1'b1, 1'b1, 2'b00, 2'b01);
        upd_valid = 2'b11;
        step();
        upd_valid = 2'b00;
        flush_to(p1);
        check(1'b1, miss[1], "second candidate not written");
        check(2'b00, taken, "no prediction for second candidate");
        flush_to(p0);
        check(1'b0, miss[0], "first candidate written");
        check(2'b01, taken, "first candidate taken");
        check(t0, target[0], "first candidate target");
    endtask

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout: tests still running after %0d cycles", WATCHDOG_CYCLES);
        stop_failed();
    end

    initial begin
        seed          = 86;
        rst           = 1'b1;
        flush         = 1'b0;
        redir_addr    = '0;
        ready         = 1'b0;
        upd_valid     = '0;
        upd_pc        = '0;
        upd_target    = '0;
        upd_type[0]   = NORMAL;
        upd_type[1]   = NORMAL;
        upd_is_branch = '0;
        upd_taken     = '0;
        upd_type_miss = '0;
        upd_hist      = '0;
        upd_scnt      = '0;

        reset_and_sequential();
        flush_redirect();
        jump_training();
        counter_training();
        call_return();
        two_corrections();

        $display("TEST PASS");
        $finish;
    end

endmodule

// ==== bpu_top.f ====
rtl/bpu_cfg_pkg.sv
rtl/bpu_types_pkg.sv
rtl/bpu_update_if.sv
rtl/bpu_lookup_if.sv
rtl/bpu_update_ctrl.sv
rtl/bpu_btb.sv
rtl/bpu_dir_pred.sv
rtl/bpu_ras.sv
rtl/bpu_pc_gen.sv
rtl/bpu_top.sv
tb/bpu_sva.sv
tb/bpu_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the branch predictor testbench with Verilator, run it, check the log

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --assert -Wno-fatal --top-module bpu_tb -f bpu_top.f -o bpu_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/bpu_sim > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "^TEST PASS$" "$LOG"; then
    exit 0
fi
echo "pass line not found in $LOG"
exit 1
